/* cache_geom_pkg.sv */
package cache_geom_pkg;

    // physical address and CPU word
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;

    // line layout, four words per line
    localparam int OFFSET_W   = 4;
    localparam int BANKS      = 4;
    localparam int BANK_SEL_W = 2;
    localparam int STRB_W     = 4;  // byte lanes per word
    localparam int LINE_W     = 128;

endpackage

/* cache_ctrl_pkg.sv */
package cache_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REPLACE,
        REFILL
    } main_state_e;

    typedef enum logic {
        S_EMPTY,
        S_WRITE
    } store_state_e;

    localparam logic [2:0] LINE_XFER_TYPE = 3'b100;  // whole 16-byte line

endpackage

/* sram_1p.sv */
`timescale 1ns/1ps

module sram_1p #(
    parameter int DEPTH_W = 8,
    parameter int DATA_W  = 32
) (
    input  logic                              clk,
    input  logic [cache_geom_pkg::STRB_W-1:0] we,
    input  logic [DEPTH_W-1:0]                addr,
    input  logic [DATA_W-1:0]                 din,
    output logic [DATA_W-1:0]                 dout
);

    logic [DATA_W-1:0] mem [2**DEPTH_W];

    // read returns the old word on a write to the same address
    always_ff @(posedge clk)
    begin
        for (int b = 0; b < DATA_W; b++)
        begin
            if (we[b / 8])  // byte lane of this bit
            begin
                mem[addr][b] <= din[b];
            end
        end
        dout <= mem[addr];
    end

endmodule

/* cache_way.sv */
`timescale 1ns/1ps

module cache_way #(
    parameter int INDEX_W = 8
) (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic [INDEX_W-1:0]                         lookup_index,
    input  logic                                       use_lookup,
    input  logic [INDEX_W-1:0]                         req_index,
    input  logic [cache_geom_pkg::ADDR_W-INDEX_W-cache_geom_pkg::OFFSET_W-1:0] req_tag,
    input  logic                                       tag_we,
    input  logic                                       dirty_we,
    input  logic                                       dirty_val,
    input  logic                                       fill_we,
    input  logic [cache_geom_pkg::BANK_SEL_W-1:0]      fill_bank,
    input  logic [cache_geom_pkg::WORD_W-1:0]          fill_data,
    input  logic                                       st_we,
    input  logic [cache_geom_pkg::BANK_SEL_W-1:0]      st_bank,
    input  logic [INDEX_W-1:0]                         st_index,
    input  logic [cache_geom_pkg::STRB_W-1:0]          st_strb,
    input  logic [cache_geom_pkg::WORD_W-1:0]          st_data,
    output logic                                       hit,
    output logic                                       victim_valid,
    output logic                                       victim_dirty,
    output logic [cache_geom_pkg::ADDR_W-INDEX_W-cache_geom_pkg::OFFSET_W-1:0] victim_tag,
    output logic [cache_geom_pkg::LINE_W-1:0]          line
);

    localparam int TAG_W = cache_geom_pkg::ADDR_W - INDEX_W - cache_geom_pkg::OFFSET_W;

    logic [INDEX_W-1:0]    tag_addr;
    logic [2**INDEX_W-1:0] valid_q;
    logic [2**INDEX_W-1:0] dirty_q;
    logic                  valid_rd_q;  // follows the tag RAM read latency

    assign tag_addr = use_lookup ? lookup_index : req_index;

    sram_1p #(.DEPTH_W(INDEX_W), .DATA_W(TAG_W)) i_tag_ram (
        .clk  (clk),
        .we   ({cache_geom_pkg::STRB_W{tag_we}}),
        .addr (tag_addr),
        .din  (req_tag),
        .dout (victim_tag)
    );

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_q    <= '0;
            dirty_q    <= '0;
            valid_rd_q <= 1'b0;
        end
        else
        begin
            valid_rd_q <= valid_q[tag_addr];
            if (tag_we)
                valid_q[req_index] <= 1'b1;
            if (dirty_we)
                dirty_q[req_index] <= dirty_val;
        end
    end

    for (genvar b = 0; b < cache_geom_pkg::BANKS; b++)
    begin : g_bank
        logic                              store_sel;
        logic [cache_geom_pkg::STRB_W-1:0] bank_we;
        logic [INDEX_W-1:0]                bank_addr;

        assign store_sel = st_we && st_bank == cache_geom_pkg::BANK_SEL_W'(b);
        assign bank_we   = store_sel ? st_strb
                         : {cache_geom_pkg::STRB_W{fill_we && fill_bank == b[1:0]}};
        // pending store steals this bank's port
        assign bank_addr = store_sel ? st_index : tag_addr;

        sram_1p #(.DEPTH_W(INDEX_W), .DATA_W(cache_geom_pkg::WORD_W)) i_bank (
            .clk  (clk),
            .we   (bank_we),
            .addr (bank_addr),
            .din  (st_we ? st_data : fill_data),
            .dout (line[b*cache_geom_pkg::WORD_W +: cache_geom_pkg::WORD_W])
        );
    end

    assign victim_valid = valid_rd_q;
    assign victim_dirty = dirty_q[req_index];
    assign hit          = valid_rd_q && victim_tag == req_tag;

    // store drains right after lookup, refill only after a miss
    assert property (@(posedge clk) disable iff (rst) !(fill_we && st_we));

endmodule

/* store_buffer.sv */
`timescale 1ns/1ps

module store_buffer #(
    parameter int INDEX_W = 8
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  load,
    input  logic                                  load_way,
    input  logic [INDEX_W-1:0]                    load_index,
    input  logic [cache_geom_pkg::BANK_SEL_W-1:0] load_bank,
    input  logic [cache_geom_pkg::STRB_W-1:0]     load_strb,
    input  logic [cache_geom_pkg::WORD_W-1:0]     load_data,
    input  logic                                  req_valid,
    input  logic [cache_geom_pkg::BANK_SEL_W-1:0] req_bank,
    output logic                                  conflict,
    output logic [1:0]                            st_we_way,
    output logic [cache_geom_pkg::BANK_SEL_W-1:0] st_bank,
    output logic [INDEX_W-1:0]                    st_index,
    output logic [cache_geom_pkg::STRB_W-1:0]     st_strb,
    output logic [cache_geom_pkg::WORD_W-1:0]     st_data
);

    cache_ctrl_pkg::store_state_e state_q;
    logic                         way_q;

    always_ff @(posedge clk)
    begin
        if (rst)
            state_q <= cache_ctrl_pkg::S_EMPTY;
        else
            state_q <= load ? cache_ctrl_pkg::S_WRITE : cache_ctrl_pkg::S_EMPTY;
    end

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            way_q    <= load_way;
            st_index <= load_index;
            st_bank  <= load_bank;
            st_strb  <= load_strb;
            st_data  <= load_data;
        end
    end

    assign st_we_way[0] = state_q == cache_ctrl_pkg::S_WRITE && !way_q;
    assign st_we_way[1] = state_q == cache_ctrl_pkg::S_WRITE && way_q;

    // new lookup would read the bank being written
    assign conflict = state_q == cache_ctrl_pkg::S_WRITE && req_valid && req_bank == st_bank;

    // controller passes through idle between two lookups
    assert property (@(posedge clk) disable iff (rst) load |-> state_q == cache_ctrl_pkg::S_EMPTY);

endmodule

/* cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl #(
    parameter int         INDEX_W   = 8,
    parameter logic [2:0] LFSR_SEED = 3'b111
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  valid,
    input  logic                                  op,
    input  logic [INDEX_W-1:0]                    index,
    input  logic [cache_geom_pkg::ADDR_W-INDEX_W-cache_geom_pkg::OFFSET_W-1:0] tag,
    input  logic [cache_geom_pkg::OFFSET_W-1:0]   offset,
    input  logic [cache_geom_pkg::STRB_W-1:0]     wstrb,
    input  logic [cache_geom_pkg::WORD_W-1:0]     wdata,
    output logic                                  addr_ok,
    output logic                                  data_ok,
    output logic [cache_geom_pkg::WORD_W-1:0]     rdata,
    output logic                                  rd_req,
    output logic [2:0]                            rd_type,
    output logic [cache_geom_pkg::ADDR_W-1:0]     rd_addr,
    input  logic                                  rd_rdy,
    input  logic                                  ret_valid,
    input  logic                                  ret_last,
    input  logic [cache_geom_pkg::WORD_W-1:0]     ret_data,
    input  logic                                  wr_rdy,
    output logic                                  wr_req,
    output logic [2:0]                            wr_type,
    output logic [cache_geom_pkg::ADDR_W-1:0]     wr_addr,
    output logic [cache_geom_pkg::STRB_W-1:0]     wr_wstrb,
    output logic [cache_geom_pkg::LINE_W-1:0]     wr_data,
    input  logic [1:0]                            way_hit,
    input  logic [1:0]                            way_valid,
    input  logic [1:0]                            way_dirty,
    input  logic [1:0][cache_geom_pkg::ADDR_W-INDEX_W-cache_geom_pkg::OFFSET_W-1:0] way_tag,
    input  logic [1:0][cache_geom_pkg::LINE_W-1:0] way_line,
    output logic                                  use_lookup,
    output logic [INDEX_W-1:0]                    req_index,
    output logic [cache_geom_pkg::ADDR_W-INDEX_W-cache_geom_pkg::OFFSET_W-1:0] req_tag,
    output logic [1:0]                            tag_we,
    output logic [1:0]                            dirty_we,
    output logic                                  dirty_val,
    output logic [1:0]                            fill_we,
    output logic [cache_geom_pkg::BANK_SEL_W-1:0] fill_bank,
    output logic [cache_geom_pkg::WORD_W-1:0]     fill_data,
    output logic                                  load,
    output logic                                  load_way,
    output logic [cache_geom_pkg::BANK_SEL_W-1:0] load_bank,
    output logic [cache_geom_pkg::STRB_W-1:0]     load_strb,
    output logic [cache_geom_pkg::WORD_W-1:0]     load_data,
    input  logic                                  conflict
);

    cache_ctrl_pkg::main_state_e state_q, state_d;

    logic                                  op_q;
    logic [cache_geom_pkg::OFFSET_W-1:0]   offset_q;
    logic [cache_geom_pkg::BANK_SEL_W-1:0] req_bank;
    logic [cache_geom_pkg::BANK_SEL_W-1:0] ret_count;
    logic [2:0]                            lfsr;
    logic                                  accept;
    logic                                  hit;
    logic                                  hit_way;
    logic                                  victim_way;
    logic                                  refill_beat;
    logic                                  refill_done;
    logic [cache_geom_pkg::WORD_W-1:0]     merged;

    assign accept      = valid && addr_ok;
    assign hit         = |way_hit;
    assign hit_way     = way_hit[1];
    assign victim_way  = lfsr[0];
    assign req_bank    = offset_q[cache_geom_pkg::OFFSET_W-1 -: cache_geom_pkg::BANK_SEL_W];
    assign refill_beat = state_q == cache_ctrl_pkg::REFILL && ret_valid;
    assign refill_done = refill_beat && ret_last;

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            cache_ctrl_pkg::IDLE:    if (accept) state_d = cache_ctrl_pkg::LOOKUP;
            cache_ctrl_pkg::LOOKUP:  state_d = hit ? cache_ctrl_pkg::IDLE : cache_ctrl_pkg::MISS;
            cache_ctrl_pkg::MISS:    if (wr_rdy) state_d = cache_ctrl_pkg::REPLACE;
            cache_ctrl_pkg::REPLACE: if (rd_req && rd_rdy) state_d = cache_ctrl_pkg::REFILL;
            cache_ctrl_pkg::REFILL:  if (refill_done) state_d = cache_ctrl_pkg::IDLE;
            default:                 state_d = cache_ctrl_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q   <= cache_ctrl_pkg::IDLE;
            ret_count <= '0;
            lfsr      <= LFSR_SEED;
            wr_req    <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            if (refill_beat)
                ret_count <= ret_count + 1'b1;  // wraps after beat 3
            if (refill_done)
                lfsr <= {lfsr[1], lfsr[0] ^ lfsr[2], lfsr[2]};
            // one-cycle pulse entering replace, dirty victim only
            wr_req <= state_q == cache_ctrl_pkg::MISS && wr_rdy
                   && way_valid[victim_way] && way_dirty[victim_way];
        end
    end

    // request buffer
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            op_q      <= op;
            req_index <= index;
            req_tag   <= tag;
            offset_q  <= offset;
            load_strb <= wstrb;
            load_data <= wdata;
        end
    end

    // store bytes replace the matching refill beat
    always_comb
    begin
        merged = ret_data;
        if (op_q && ret_count == req_bank)
        begin
            for (int i = 0; i < cache_geom_pkg::STRB_W; i++)
            begin
                if (load_strb[i])
                    merged[i*8 +: 8] = load_data[i*8 +: 8];
            end
        end
    end

    assign addr_ok = state_q == cache_ctrl_pkg::IDLE && !conflict;
    assign data_ok = (state_q == cache_ctrl_pkg::LOOKUP && hit)
                  || (refill_beat && ret_count == req_bank);
    assign rdata   = state_q == cache_ctrl_pkg::LOOKUP
                   ? way_line[hit_way][req_bank*cache_geom_pkg::WORD_W +: cache_geom_pkg::WORD_W]
                   : merged;

    // read waits out the eviction pulse
    assign rd_req   = state_q == cache_ctrl_pkg::REPLACE && !wr_req;
    assign rd_type  = cache_ctrl_pkg::LINE_XFER_TYPE;
    assign rd_addr  = {req_tag, req_index, {cache_geom_pkg::OFFSET_W{1'b0}}};
    assign wr_type  = cache_ctrl_pkg::LINE_XFER_TYPE;
    assign wr_addr  = {way_tag[victim_way], req_index, {cache_geom_pkg::OFFSET_W{1'b0}}};
    assign wr_wstrb = '1;
    assign wr_data  = way_line[victim_way];

    assign use_lookup = accept;
    assign dirty_val  = op_q;  // write hit sets, refill end takes the request op
    assign fill_bank  = ret_count;
    assign fill_data  = merged;

    assign load      = state_q == cache_ctrl_pkg::LOOKUP && hit && op_q;
    assign load_way  = hit_way;
    assign load_bank = req_bank;

    for (genvar w = 0; w < 2; w++)
    begin : g_way_ctl
        assign tag_we[w]   = refill_done && victim_way == w[0];
        assign fill_we[w]  = refill_beat && victim_way == w[0];
        assign dirty_we[w] = tag_we[w] || (load && hit_way == w[0]);
    end

    assert property (@(posedge clk) disable iff (rst) wr_req |-> state_q == cache_ctrl_pkg::REPLACE);
    // read request held until granted
    assert property (@(posedge clk) disable iff (rst) rd_req && !rd_rdy |=> rd_req);

endmodule

/* cache_top.sv */
`timescale 1ns/1ps

module cache_top #(
    parameter int         INDEX_W   = 8,
    parameter logic [2:0] LFSR_SEED = 3'b111
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                valid,
    input  logic                                op,
    input  logic [INDEX_W-1:0]                  index,
    input  logic [cache_geom_pkg::ADDR_W-INDEX_W-cache_geom_pkg::OFFSET_W-1:0] tag,
    input  logic [cache_geom_pkg::OFFSET_W-1:0] offset,
    output logic                                addr_ok,
    output logic                                data_ok,
    output logic [cache_geom_pkg::WORD_W-1:0]   rdata,
    input  logic [cache_geom_pkg::STRB_W-1:0]   wstrb,
    input  logic [cache_geom_pkg::WORD_W-1:0]   wdata,
    output logic                                rd_req,
    output logic [2:0]                          rd_type,
    output logic [cache_geom_pkg::ADDR_W-1:0]   rd_addr,
    input  logic                                rd_rdy,
    input  logic                                ret_valid,
    input  logic                                ret_last,
    input  logic [cache_geom_pkg::WORD_W-1:0]   ret_data,
    input  logic                                wr_rdy,
    output logic                                wr_req,
    output logic [2:0]                          wr_type,
    output logic [cache_geom_pkg::ADDR_W-1:0]   wr_addr,
    output logic [cache_geom_pkg::STRB_W-1:0]   wr_wstrb,
    output logic [cache_geom_pkg::LINE_W-1:0]   wr_data
);

    localparam int TAG_W = cache_geom_pkg::ADDR_W - INDEX_W - cache_geom_pkg::OFFSET_W;

    logic                                  use_lookup;
    logic [INDEX_W-1:0]                    req_index;
    logic [TAG_W-1:0]                      req_tag;
    logic [1:0]                            tag_we;
    logic [1:0]                            dirty_we;
    logic                                  dirty_val;
    logic [1:0]                            fill_we;
    logic [cache_geom_pkg::BANK_SEL_W-1:0] fill_bank;
    logic [cache_geom_pkg::WORD_W-1:0]     fill_data;
    logic [1:0]                            way_hit;
    logic [1:0]                            way_valid;
    logic [1:0]                            way_dirty;
    logic [1:0][TAG_W-1:0]                 way_tag;
    logic [1:0][cache_geom_pkg::LINE_W-1:0] way_line;
    logic                                  sb_load;
    logic                                  sb_way;
    logic [cache_geom_pkg::BANK_SEL_W-1:0] sb_bank;
    logic [cache_geom_pkg::STRB_W-1:0]     sb_strb;
    logic [cache_geom_pkg::WORD_W-1:0]     sb_data;
    logic                                  conflict;
    logic [1:0]                            st_we_way;
    logic [cache_geom_pkg::BANK_SEL_W-1:0] st_bank;
    logic [INDEX_W-1:0]                    st_index;
    logic [cache_geom_pkg::STRB_W-1:0]     st_strb;
    logic [cache_geom_pkg::WORD_W-1:0]     st_data;

    cache_ctrl #(.INDEX_W(INDEX_W), .LFSR_SEED(LFSR_SEED)) i_ctrl (
        .clk, .rst, .valid, .op, .index, .tag, .offset, .wstrb, .wdata,
        .addr_ok, .data_ok, .rdata,
        .rd_req, .rd_type, .rd_addr, .rd_rdy, .ret_valid, .ret_last, .ret_data,
        .wr_rdy, .wr_req, .wr_type, .wr_addr, .wr_wstrb, .wr_data,
        .way_hit, .way_valid, .way_dirty, .way_tag, .way_line,
        .use_lookup, .req_index, .req_tag, .tag_we, .dirty_we, .dirty_val,
        .fill_we, .fill_bank, .fill_data,
        .load (sb_load), .load_way (sb_way), .load_bank (sb_bank),
        .load_strb (sb_strb), .load_data (sb_data), .conflict
    );

    store_buffer #(.INDEX_W(INDEX_W)) i_store (
        .clk, .rst,
        .load (sb_load), .load_way (sb_way), .load_index (req_index),
        .load_bank (sb_bank), .load_strb (sb_strb), .load_data (sb_data),
        .req_valid (valid),
        .req_bank (offset[cache_geom_pkg::OFFSET_W-1 -: cache_geom_pkg::BANK_SEL_W]),
        .conflict, .st_we_way, .st_bank, .st_index, .st_strb, .st_data
    );

    for (genvar w = 0; w < 2; w++)
    begin : g_way
        cache_way #(.INDEX_W(INDEX_W)) i_way (
            .clk, .rst,
            .lookup_index (index), .use_lookup, .req_index, .req_tag,
            .tag_we (tag_we[w]), .dirty_we (dirty_we[w]), .dirty_val,
            .fill_we (fill_we[w]), .fill_bank, .fill_data,
            .st_we (st_we_way[w]), .st_bank, .st_index, .st_strb, .st_data,
            .hit (way_hit[w]), .victim_valid (way_valid[w]), .victim_dirty (way_dirty[w]),
            .victim_tag (way_tag[w]), .line (way_line[w])
        );
    end

endmodule

/* mem_model.sv */
`timescale 1ns/1ps

module mem_model (
    input  logic         clk,
    input  logic         rst,
    input  logic         rd_req,
    input  logic [2:0]   rd_type,
    input  logic [31:0]  rd_addr,
    output logic         rd_rdy,
    output logic         ret_valid,
    output logic         ret_last,
    output logic [31:0]  ret_data,
    input  logic         wr_req,
    input  logic [2:0]   wr_type,
    input  logic [31:0]  wr_addr,
    input  logic [127:0] wr_data,
    output logic         wr_rdy
);

    logic [127:0] lines [logic [31:0]];  // written-back lines only
    logic         busy;
    logic [31:0]  line_addr;
    logic [1:0]   beat;

    // untouched memory, every bit of the word address matters
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return ({addr[31:2], 2'b00} * 32'h9e37_79b1) ^ 32'hc3a5_0f1e;
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        logic [31:0] key;
        key = {addr[31:4], 4'b0000};
        if (lines.exists(key))
            return lines[key][addr[3:2]*32 +: 32];
        return fill_word(addr);
    endfunction

    initial
    begin
        rd_rdy    = 1'b0;
        wr_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        busy      = 1'b0;
        line_addr = '0;
        beat      = '0;
    end

    always @(posedge clk)
    begin
        if (rst)
        begin
            rd_rdy    <= 1'b0;
            wr_rdy    <= 1'b0;
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            busy      <= 1'b0;
            beat      <= '0;
        end
        else
        begin
            wr_rdy <= ($urandom % 4) != 0;
            if (wr_req && wr_type == cache_ctrl_pkg::LINE_XFER_TYPE)
                lines[{wr_addr[31:4], 4'b0000}] = wr_data;
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            if (!busy)
            begin
                rd_rdy <= ($urandom % 3) != 0;
                if (rd_req && rd_rdy && rd_type == cache_ctrl_pkg::LINE_XFER_TYPE)
                begin
                    busy      <= 1'b1;
                    rd_rdy    <= 1'b0;
                    line_addr <= {rd_addr[31:4], 4'b0000};
                    beat      <= '0;
                end
            end
            else if (($urandom % 4) != 0)  // gaps between beats
            begin
                ret_valid <= 1'b1;
                ret_data  <= read_word(line_addr + {28'd0, beat, 2'b00});
                ret_last  <= beat == 2'd3;
                beat      <= beat + 2'd1;
                if (beat == 2'd3)
                    busy <= 1'b0;
            end
        end
    end

endmodule

/* cache_tb.sv */
`timescale 1ns/1ps

module cache_tb;

    localparam int NUM_REQS       = 400;
    localparam int TIMEOUT_CYCLES = NUM_REQS * 24;

    logic         clk = 1'b0;
    logic         rst;
    logic         valid;
    logic         op;
    logic [7:0]   index;
    logic [19:0]  tag;
    logic [3:0]   offset;
    logic [3:0]   wstrb;
    logic [31:0]  wdata;
    logic         addr_ok;
    logic         data_ok;
    logic [31:0]  rdata;
    logic         rd_req;
    logic [2:0]   rd_type;
    logic [31:0]  rd_addr;
    logic         rd_rdy;
    logic         ret_valid;
    logic         ret_last;
    logic [31:0]  ret_data;
    logic         wr_rdy;
    logic         wr_req;
    logic [2:0]   wr_type;
    logic [31:0]  wr_addr;
    logic [3:0]   wr_wstrb;
    logic [127:0] wr_data;

    logic [31:0]  ref_mem [logic [31:0]];  // word address to latest value
    logic [31:0]  exp_line_addr;
    int           cycles;

    always #20 clk = ~clk;

    cache_top #(.INDEX_W(8), .LFSR_SEED(3'b111)) i_dut (.*);

    mem_model i_mem (.*);

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return ({addr[31:2], 2'b00} * 32'h9e37_79b1) ^ 32'hc3a5_0f1e;
    endfunction

    function automatic logic [31:0] ref_word(input logic [31:0] addr);
        logic [31:0] key;
        key = {addr[31:2], 2'b00};
        if (ref_mem.exists(key))
            return ref_mem[key];
        return fill_word(key);
    endfunction

    function automatic logic [127:0] ref_line(input logic [31:0] addr);
        logic [127:0] line;
        for (int b = 0; b < 4; b++)
            line[b*32 +: 32] = ref_word({addr[31:4], 2'(b), 2'b00});
        return line;
    endfunction

    task automatic stop_with_failure();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic run_request(input logic wr, input logic [7:0] idx, input logic [19:0] tg,
                               input logic [3:0] off, input logic [3:0] strb,
                               input logic [31:0] data);
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] expected;
        addr = {tg, idx, off};
        valid  <= 1'b1;
        op     <= wr;
        index  <= idx;
        tag    <= tg;
        offset <= off;
        wstrb  <= strb;
        wdata  <= data;
        @(posedge clk);
        while (!(valid && addr_ok))
            @(posedge clk);
        valid <= 1'b0;
        exp_line_addr = {addr[31:4], 4'b0000};
        if (wr)
        begin
            word = ref_word(addr);
            for (int i = 0; i < 4; i++)
                if (strb[i])
                    word[i*8 +: 8] = data[i*8 +: 8];
            ref_mem[{addr[31:2], 2'b00}] = word;
        end
        expected = ref_word(addr);
        @(posedge clk);
        while (!data_ok)
            @(posedge clk);
        if (!wr)
            assert (rdata == expected)
            else
            begin
                $display("error at %0t: rdata got %h expected %h", $time, rdata, expected);
                stop_with_failure();
            end
    endtask

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles, the cache stopped answering", cycles);
            stop_with_failure();
        end
    end

    // memory bus requests, sampled before the edge
    always @(posedge clk)
    begin
        if (!rst && rd_req)
        begin
            assert (rd_addr == exp_line_addr)
            else
            begin
                $display("error at %0t: rd_addr got %h expected %h", $time, rd_addr,
                         exp_line_addr);
                stop_with_failure();
            end
            assert (rd_type == cache_ctrl_pkg::LINE_XFER_TYPE)
            else
            begin
                $display("error at %0t: rd_type got %b expected %b", $time, rd_type,
                         cache_ctrl_pkg::LINE_XFER_TYPE);
                stop_with_failure();
            end
        end
        if (!rst && wr_req)
        begin
            assert (wr_addr[3:0] == 4'h0)
            else
            begin
                $display("error at %0t: wr_addr[3:0] got %h expected 0", $time,
                         wr_addr[3:0]);
                stop_with_failure();
            end
            assert (wr_wstrb == 4'hf)
            else
            begin
                $display("error at %0t: wr_wstrb got %b expected 1111", $time, wr_wstrb);
                stop_with_failure();
            end
            assert (wr_type == cache_ctrl_pkg::LINE_XFER_TYPE)
            else
            begin
                $display("error at %0t: wr_type got %b expected %b", $time, wr_type,
                         cache_ctrl_pkg::LINE_XFER_TYPE);
                stop_with_failure();
            end
            assert (wr_data == ref_line(wr_addr))
            else
            begin
                $display("error at %0t: wr_data got %h expected %h", $time, wr_data,
                         ref_line(wr_addr));
                stop_with_failure();
            end
        end
    end

    // hit answers one cycle after acceptance
    assert property (@(posedge clk) disable iff (rst)
        (i_dut.i_ctrl.state_q == cache_ctrl_pkg::LOOKUP && data_ok) |-> $past(valid && addr_ok))
    else
    begin
        $display("data_ok in lookup at %0t did not follow an acceptance by one cycle", $time);
        stop_with_failure();
    end

    initial
    begin
        logic        wr;
        logic [7:0]  idx;
        logic [19:0] tg;
        logic [3:0]  off;
        logic [3:0]  strb;
        logic [31:0] data;
        int          n;
        void'($urandom(93));
        rst    = 1'b1;
        valid  = 1'b0;
        op     = 1'b0;
        index  = '0;
        tag    = '0;
        offset = '0;
        wstrb  = '0;
        wdata  = '0;
        cycles = 0;
        exp_line_addr = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        assert (addr_ok && !data_ok && !rd_req && !wr_req)
        else
        begin
            $display("error at %0t: after reset addr_ok %b data_ok %b rd_req %b wr_req %b",
                     $time, addr_ok, data_ok, rd_req, wr_req);
            $display("error at %0t: after reset expected addr_ok 1 data_ok 0 rd_req 0 wr_req 0",
                     $time);
            stop_with_failure();
        end
        n = 0;
        while (n < NUM_REQS)
        begin
            wr   = 1'($urandom % 2);
            idx  = 8'($urandom % 4) * 8'd16;  // 4 sets, 6 tags, 2 ways
            tg   = 20'h00100 + 20'($urandom % 6);
            off  = {2'($urandom % 4), 2'b00};
            strb = 4'($urandom % 15 + 1);
            data = $urandom;
            run_request(wr, idx, tg, off, strb, data);
            n++;
            // read straight behind the store hits the bank conflict
            if (wr && n < NUM_REQS && ($urandom % 3) == 0)
            begin
                run_request(1'b0, idx, tg, off, 4'h0, 32'h0);
                n++;
            end
        end
        @(posedge clk);
        $display("all tests passed");
        $finish;
    end

endmodule

/* filelist.f */
cache_geom_pkg.sv
cache_ctrl_pkg.sv
sram_1p.sv
cache_way.sv
store_buffer.sv
cache_ctrl.sv
cache_top.sv
mem_model.sv
cache_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the cache testbench with Verilator
verilator --binary --timing --assert -f filelist.f --top-module cache_tb -o sim_cache \
    && ./obj_dir/sim_cache > sim.log 2>&1 \
    ; cat sim.log \
    && ! grep -q "tests failed" sim.log \
    && echo "simulation ok" \
    || { echo "simulation failed"; exit 1; }
